// ==== hw/gpio_params.svh ====
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

// Pin count fixed by the 5-bit pin field
`define GPIO_PINS 32

// APB bus widths
`define GPIO_ADDR_W 16
`define GPIO_DATA_W 16

// Field positions inside PADDR
`define GPIO_PIN_LSB 0
`define GPIO_OP_LSB 8

`endif

// ==== hw/gpioPkg.sv ====
package gpioPkg;

    // Cell operation, carried in PADDR[10:8]
    typedef enum logic [2:0] {
        opSet    = 3'd1,
        opPulse  = 3'd2,
        opSample = 3'd4
    } cellOpE;

    // Bus phase seen by the decode FSM
    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stAccess,
        stWait
    } apbStateE;

endpackage

// ==== hw/apbCommandDecode.sv ====
`include "gpio_params.svh"

module apbCommandDecode (
    input  logic                    clk2p5,
    input  logic                    rstN,
    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [`GPIO_ADDR_W-1:0] PADDR,
    input  logic [`GPIO_DATA_W-1:0] PWDATA,
    output logic [4:0]              pinSel,
    output gpioPkg::cellOpE         cellOp,
    output logic [1:0]              writeData,
    output logic                    cellStrobe,
    output logic                    accessStart,
    output logic                    isRead,
    output logic                    opError
);

    gpioPkg::apbStateE state;
    gpioPkg::apbStateE busPhase;
    gpioPkg::apbStateE nextState;
    logic [2:0]        opField;
    logic              opKnown;
    logic              opBad;

    assign opField = PADDR[`GPIO_OP_LSB +: 3];

    // Only the three one-hot encodings are legal
    always_comb begin
        case (opField)
            gpioPkg::opSet,
            gpioPkg::opPulse,
            gpioPkg::opSample: opKnown = 1'b1;
            default:           opKnown = 1'b0;
        endcase
    end

    // Reads must carry Sample
    always_comb begin
        if (PWRITE) begin
            opBad = !opKnown;
        end else begin
            opBad = (opField != gpioPkg::opSample);
        end
    end

    // Setup is recognised in the cycle it is on the bus
    always_comb begin
        busPhase = state;
        if (state == gpioPkg::stIdle && PSEL && !PENABLE) begin
            busPhase = gpioPkg::stSetup;
        end
    end

    always_comb begin
        case (busPhase)
            gpioPkg::stSetup:  nextState = gpioPkg::stAccess;
            gpioPkg::stAccess: nextState = gpioPkg::stWait;
            default:           nextState = gpioPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk2p5) begin
        if (!rstN) begin
            state <= gpioPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    // Fields captured once per transfer at the setup edge
    always_ff @(posedge clk2p5) begin
        if (busPhase == gpioPkg::stSetup) begin
            pinSel    <= PADDR[`GPIO_PIN_LSB +: 5];
            cellOp    <= gpioPkg::cellOpE'(opField);
            writeData <= PWDATA[1:0];
            isRead    <= !PWRITE;
            opError   <= opBad;
        end
    end

    // First access cycle
    assign accessStart = (state == gpioPkg::stAccess);

    // Strobe for legal writes only
    assign cellStrobe = accessStart && !isRead && !opError;

endmodule

// ==== hw/gpioCell.sv ====
module gpioCell (
    input  logic            clk2p5,
    input  logic            rstN,
    input  logic            cellSelect,
    input  gpioPkg::cellOpE cellOp,
    input  logic [1:0]      writeData,
    input  logic            pinIn,
    output logic            outValue,
    output logic            outEnable,
    output logic            sampledIn
);

    always_ff @(posedge clk2p5) begin
        if (!rstN) begin
            outValue  <= 1'b0;
            outEnable <= 1'b0;
            sampledIn <= 1'b0;
        end else if (cellSelect) begin
            case (cellOp)
                gpioPkg::opSet: begin
                    outValue  <= writeData[0];
                    outEnable <= writeData[1];
                end
                gpioPkg::opPulse: begin
                    // Toggle polarity with the enable untouched
                    outValue <= ~outValue;
                end
                gpioPkg::opSample: begin
                    sampledIn <= pinIn;
                end
                default: begin
                    outValue <= outValue;
                end
            endcase
        end
    end

endmodule

// ==== hw/gpioCellBank.sv ====
`include "gpio_params.svh"

module gpioCellBank (
    input  logic                  clk2p5,
    input  logic                  rstN,
    input  logic [4:0]            pinSel,
    input  gpioPkg::cellOpE       cellOp,
    input  logic [1:0]            writeData,
    input  logic                  cellStrobe,
    input  logic [`GPIO_PINS-1:0] ioIn,
    output logic [`GPIO_PINS-1:0] ioOut,
    output logic [`GPIO_PINS-1:0] ioOutEnable,
    output logic [2:0]            stateWord
);

    logic [`GPIO_PINS-1:0] cellSelect;
    logic [`GPIO_PINS-1:0] sampledIn;

    // One-hot select qualified by the strobe
    always_comb begin
        for (int i = 0; i < `GPIO_PINS; i++) begin
            cellSelect[i] = cellStrobe && (pinSel == 5'(i));
        end
    end

    for (genvar i = 0; i < `GPIO_PINS; i++) begin : gCell
        gpioCell u_cell (
            .clk2p5     (clk2p5),
            .rstN       (rstN),
            .cellSelect (cellSelect[i]),
            .cellOp     (cellOp),
            .writeData  (writeData),
            .pinIn      (ioIn[i]),
            .outValue   (ioOut[i]),
            .outEnable  (ioOutEnable[i]),
            .sampledIn  (sampledIn[i])
        );
    end

    // {outEnable, outValue, sampledIn} of the addressed pin
    assign stateWord = {ioOutEnable[pinSel], ioOut[pinSel], sampledIn[pinSel]};

endmodule

// ==== hw/apbResponse.sv ====
`include "gpio_params.svh"

module apbResponse (
    input  logic                    clk2p5,
    input  logic                    rstN,
    input  logic                    accessStart,
    input  logic                    isRead,
    input  logic                    opError,
    input  logic [2:0]              stateWord,
    output logic                    PREADY,
    output logic [`GPIO_DATA_W-1:0] PRDATA,
    output logic                    PSLVERR
);

    logic                    readValid;
    logic [`GPIO_DATA_W-1:0] readData;

    assign readValid = accessStart && isRead && !opError;

    // stateWord is still the pre-update state here
    assign readData = {{(`GPIO_DATA_W - 3){1'b0}}, stateWord};

    // Completion one cycle after accessStart and held for a single cycle
    always_ff @(posedge clk2p5) begin
        if (!rstN) begin
            PREADY  <= 1'b0;
            PSLVERR <= 1'b0;
            PRDATA  <= '0;
        end else begin
            PREADY  <= accessStart;
            PSLVERR <= accessStart && opError;
            if (readValid) begin
                PRDATA <= readData;
            end else begin
                PRDATA <= '0;
            end
        end
    end

endmodule

// ==== hw/gpioController.sv ====
`include "gpio_params.svh"

module gpioController (
    input  logic                    clk2p5,
    input  logic                    rstN,

    input  logic                    PSEL,
    input  logic                    PENABLE,
    input  logic                    PWRITE,
    input  logic [`GPIO_ADDR_W-1:0] PADDR,
    input  logic [`GPIO_DATA_W-1:0] PWDATA,
    output logic [`GPIO_DATA_W-1:0] PRDATA,
    output logic                    PREADY,
    output logic                    PSLVERR,

    input  logic [`GPIO_PINS-1:0]   ioIn,
    output logic [`GPIO_PINS-1:0]   ioOut,
    output logic [`GPIO_PINS-1:0]   ioOutEnable
);

    logic [4:0]      pinSel;
    gpioPkg::cellOpE cellOp;
    logic [1:0]      writeData;
    logic            cellStrobe;
    logic            accessStart;
    logic            isRead;
    logic            opError;
    logic [2:0]      stateWord;

    // Decode
    apbCommandDecode u_decode (
        .clk2p5      (clk2p5),
        .rstN        (rstN),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .pinSel      (pinSel),
        .cellOp      (cellOp),
        .writeData   (writeData),
        .cellStrobe  (cellStrobe),
        .accessStart (accessStart),
        .isRead      (isRead),
        .opError     (opError)
    );

    // Execute
    gpioCellBank u_cellBank (
        .clk2p5      (clk2p5),
        .rstN        (rstN),
        .pinSel      (pinSel),
        .cellOp      (cellOp),
        .writeData   (writeData),
        .cellStrobe  (cellStrobe),
        .ioIn        (ioIn),
        .ioOut       (ioOut),
        .ioOutEnable (ioOutEnable),
        .stateWord   (stateWord)
    );

    // Result
    apbResponse u_response (
        .clk2p5      (clk2p5),
        .rstN        (rstN),
        .accessStart (accessStart),
        .isRead      (isRead),
        .opError     (opError),
        .stateWord   (stateWord),
        .PREADY      (PREADY),
        .PRDATA      (PRDATA),
        .PSLVERR     (PSLVERR)
    );

endmodule

// ==== verification/clockGen.sv ====
module clockGen #(
    parameter int halfPeriod = 10
) (
    output logic clk2p5
);

    // Period of 20 time units
    initial begin
        clk2p5 = 1'b0;
        forever begin
            #halfPeriod clk2p5 = ~clk2p5;
        end
    end

endmodule

// ==== verification/gpioControllerTb.sv ====
`include "gpio_params.svh"

module gpioControllerTb;

    localparam int clockPeriod = 20;
    localparam int driveDelay  = 2;
    localparam int maxWait     = 4;
    localparam int randomCount = 400;
    // Directed transfers plus the random mix rounded up
    localparam int testCount   = 600;
    localparam int watchdogTime = (testCount + 20) * 3 * clockPeriod * 2;

    logic                    clk2p5;
    logic                    rstN;
    logic                    PSEL;
    logic                    PENABLE;
    logic                    PWRITE;
    logic [`GPIO_ADDR_W-1:0] PADDR;
    logic [`GPIO_DATA_W-1:0] PWDATA;
    logic [`GPIO_DATA_W-1:0] PRDATA;
    logic                    PREADY;
    logic                    PSLVERR;
    logic [`GPIO_PINS-1:0]   ioIn;
    logic [`GPIO_PINS-1:0]   ioOut;
    logic [`GPIO_PINS-1:0]   ioOutEnable;

    integer seed = 86;
    int     issuedCount = 0;
    int     completedCount = 0;

    // Reference state of every pin
    logic [`GPIO_PINS-1:0] modelOut = '0;
    logic [`GPIO_PINS-1:0] modelOe = '0;
    logic [`GPIO_PINS-1:0] modelSampled = '0;

    clockGen u_clockGen (
        .clk2p5 (clk2p5)
    );

    gpioController u_gpioController (
        .clk2p5      (clk2p5),
        .rstN        (rstN),
        .PSEL        (PSEL),
        .PENABLE     (PENABLE),
        .PWRITE      (PWRITE),
        .PADDR       (PADDR),
        .PWDATA      (PWDATA),
        .PRDATA      (PRDATA),
        .PREADY      (PREADY),
        .PSLVERR     (PSLVERR),
        .ioIn        (ioIn),
        .ioOut       (ioOut),
        .ioOutEnable (ioOutEnable)
    );

    task automatic failRun();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            failRun();
        end
    endtask

    // Expected {PSLVERR, PRDATA} and the pin array update for legal writes
    function automatic logic [`GPIO_DATA_W:0] predictTransfer(input logic [4:0] pin,
            input logic [2:0] op, input logic write, input logic [1:0] data,
            input logic [`GPIO_PINS-1:0] pins);
        logic [`GPIO_DATA_W-1:0] rdata;
        logic                    err;
        rdata = '0;
        err   = 1'b0;
        if (write) begin
            case (op)
                gpioPkg::opSet: begin
                    modelOut[pin] = data[0];
                    modelOe[pin]  = data[1];
                end
                gpioPkg::opPulse: begin
                    modelOut[pin] = ~modelOut[pin];
                end
                gpioPkg::opSample: begin
                    modelSampled[pin] = pins[pin];
                end
                default: begin
                    err = 1'b1;
                end
            endcase
        end else if (op == gpioPkg::opSample) begin
            rdata[2:0] = {modelOe[pin], modelOut[pin], modelSampled[pin]};
        end else begin
            err = 1'b1;
        end
        return {err, rdata};
    endfunction

    function automatic logic [`GPIO_ADDR_W-1:0] busAddress(input logic [4:0] pin,
            input logic [2:0] op);
        logic [`GPIO_ADDR_W-1:0] addr;
        addr = '0;
        addr[`GPIO_PIN_LSB +: 5] = pin;
        addr[`GPIO_OP_LSB +: 3]  = op;
        return addr;
    endfunction

    // Starts and ends a driveDelay after a rising edge
    task automatic runTransfer(input logic write, input logic [4:0] pin,
            input logic [2:0] op, input logic [1:0] data,
            output logic [`GPIO_DATA_W-1:0] rdata, output logic slverr);
        logic [31:0] randomWord;
        int          waitCount;
        randomWord = $random(seed);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = write;
        PADDR   = busAddress(pin, op);
        PWDATA  = {randomWord[`GPIO_DATA_W-1:2], data};
        @(posedge clk2p5);
        #driveDelay;
        PENABLE = 1'b1;
        waitCount = 0;
        @(negedge clk2p5);
        while (PREADY !== 1'b1) begin
            waitCount++;
            if (waitCount > maxWait) begin
                $display("PREADY never rose for the transfer to pin %0d at %0t", pin, $time);
                failRun();
            end
            @(negedge clk2p5);
        end
        rdata  = PRDATA;
        slverr = PSLVERR;
        @(posedge clk2p5);
        #driveDelay;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        issuedCount++;
    endtask

    task automatic apbWrite(input logic [4:0] pin, input logic [2:0] op,
            input logic [1:0] data);
        logic [`GPIO_DATA_W-1:0] rdata;
        logic                    slverr;
        runTransfer(1'b1, pin, op, data, rdata, slverr);
    endtask

    task automatic apbRead(input logic [4:0] pin, input logic [2:0] op,
            output logic [`GPIO_DATA_W-1:0] rdata, output logic slverr);
        runTransfer(1'b0, pin, op, 2'b00, rdata, slverr);
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk2p5);
            #driveDelay;
        end
    endtask

    // Bus monitor sampling on the falling edge
    initial begin : compareTransfers
        logic [4:0]              pin;
        logic [2:0]              op;
        logic                    isWrite;
        logic [1:0]              data;
        logic [`GPIO_PINS-1:0]   pinsAtSetup;
        logic [`GPIO_DATA_W:0]   expected;
        forever begin
            @(negedge clk2p5);
            if (rstN && PSEL && !PENABLE) begin
                pin         = PADDR[`GPIO_PIN_LSB +: 5];
                op          = PADDR[`GPIO_OP_LSB +: 3];
                isWrite     = PWRITE;
                data        = PWDATA[1:0];
                pinsAtSetup = ioIn;
                @(negedge clk2p5);
                compareValue("PREADY", 32'd0, PREADY);
                compareValue("PRDATA", 32'd0, PRDATA);
                @(negedge clk2p5);
                compareValue("PREADY", 32'd1, PREADY);
                expected = predictTransfer(pin, op, isWrite, data, pinsAtSetup);
                compareValue("PRDATA", expected[`GPIO_DATA_W-1:0], PRDATA);
                compareValue("PSLVERR", expected[`GPIO_DATA_W], PSLVERR);
                compareValue("ioOut", modelOut, ioOut);
                compareValue("ioOutEnable", modelOe, ioOutEnable);
                completedCount++;
            end else if (rstN) begin
                assert (!PREADY && !PSLVERR && PRDATA == '0) else begin
                    $display("PREADY, PSLVERR or PRDATA was set at %0t outside any transfer",
                             $time);
                    failRun();
                end
            end
        end
    end

    initial begin : watchdog
        #watchdogTime;
        $display("Timeout: the tests did not finish within %0d time units", watchdogTime);
        failRun();
    end

    initial begin : stimulus
        logic [31:0]             r;
        logic [4:0]              pin;
        logic [2:0]              op;
        logic [1:0]              data;
        logic                    write;
        logic [`GPIO_DATA_W-1:0] rdata;
        logic                    slverr;
        logic [2:0]              badOps [0:4];
        rstN    = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = '0;
        PWDATA  = '0;
        ioIn    = '0;
        badOps[0] = 3'd0;
        badOps[1] = 3'd3;
        badOps[2] = 3'd5;
        badOps[3] = 3'd6;
        badOps[4] = 3'd7;
        repeat (16) @(posedge clk2p5);
        #driveDelay;
        rstN = 1'b1;

        // Reset state
        compareValue("ioOut", 32'd0, ioOut);
        compareValue("ioOutEnable", 32'd0, ioOutEnable);
        compareValue("PREADY", 32'd0, PREADY);
        compareValue("PSLVERR", 32'd0, PSLVERR);
        for (int i = 0; i < `GPIO_PINS; i++) begin
            apbRead(5'(i), gpioPkg::opSample, rdata, slverr);
        end

        // Set on every pin
        for (int i = 0; i < `GPIO_PINS; i++) begin
            r = $random(seed);
            apbWrite(5'(i), gpioPkg::opSet, r[1:0]);
        end

        // Pulse toggles one pin at a time
        for (int k = 0; k < 6; k++) begin
            r = $random(seed);
            repeat (3) begin
                apbWrite(r[4:0], gpioPkg::opPulse, 2'b00);
            end
        end

        // Sample and read back while a later ioIn change waits for the next Sample
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            pin = r[4:0];
            ioIn = $random(seed);
            apbWrite(pin, gpioPkg::opSample, 2'b00);
            apbRead(pin, gpioPkg::opSample, rdata, slverr);
            ioIn = ~ioIn;
            apbRead(pin, gpioPkg::opSample, rdata, slverr);
            apbWrite(pin, gpioPkg::opSample, 2'b00);
            apbRead(pin, gpioPkg::opSample, rdata, slverr);
            idleCycles(1);
        end

        // Refused transfers
        for (int k = 0; k < 2; k++) begin
            for (int j = 0; j < 5; j++) begin
                r = $random(seed);
                apbWrite(r[4:0], badOps[j], r[6:5]);
            end
            r = $random(seed);
            apbRead(r[4:0], gpioPkg::opSet, rdata, slverr);
            compareValue("PSLVERR", 32'd1, slverr);
            compareValue("PRDATA", 32'd0, rdata);
            apbRead(r[9:5], gpioPkg::opPulse, rdata, slverr);
            compareValue("PSLVERR", 32'd1, slverr);
            compareValue("PRDATA", 32'd0, rdata);
        end

        // Random mix with gaps of zero to two idle cycles
        for (int k = 0; k < randomCount; k++) begin
            r = $random(seed);
            case (r[3:2])
                2'd0: op = gpioPkg::opSet;
                2'd1: op = gpioPkg::opPulse;
                2'd2: op = gpioPkg::opSample;
                default: op = r[6:4];
            endcase
            write = (r[8:7] != 2'd0);
            if (!write && r[10]) begin
                op = gpioPkg::opSample;
            end
            if (r[13:12] == 2'd0) begin
                ioIn = $random(seed);
            end
            pin  = r[20:16];
            data = r[22:21];
            if (write) begin
                apbWrite(pin, op, data);
            end else begin
                apbRead(pin, op, rdata, slverr);
            end
            idleCycles(r[15:14] % 3);
        end

        idleCycles(4);
        compareValue("completed transfers", issuedCount, completedCount);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/gpioPkg.sv
hw/apbCommandDecode.sv
hw/gpioCell.sv
hw/gpioCellBank.sv
hw/apbResponse.sv
hw/gpioController.sv
verification/clockGen.sv
verification/gpioControllerTb.sv
